// ==== Makefile ====
# Verilator build and run of the memory system testbench
# Any variable below can be set on the command line, e.g. make test TOP=memSystemTb

VERILATOR ?= verilator
TOP       ?= memSystemTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
src/memSysPkg.sv
src/cacheCtrlPkg.sv
src/cacheArray.sv
src/bankedMem.sv
src/cacheController.sv
src/memSystem.sv
sim/clockGen.sv
sim/memSystemTb.sv

// ==== sim/clockGen.sv ====
/*
 * Testbench clock and reset
 * Free-running clock and a synchronous reset held for a set number of cycles.
 */
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
    parameter int Period      = 10,
    parameter int ResetCycles = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;   // Released on an edge like other stimulus
    end

endmodule

`default_nettype wire

// ==== sim/memSystemTb.sv ====
/*
 * Memory system testbench
 * Directed tests for read hits, line fills, write-through, write hits,
 * conflict eviction and stall. Data is predicted by a shadow memory and
 * hits by a shadow tag and valid table.
 */
`timescale 1ns/10ps
`default_nettype none

module memSystemTb
    import memSysPkg::*;
();

    localparam int BankLatency     = 4;
    localparam int ClockPeriod     = 10;
    localparam int ResetCycles     = 8;
    localparam int HitLatency      = 2;
    localparam int AccessLimit     = 4 * BankLatency + 20;   // Worst miss with margin
    localparam int PlannedAccesses = 64;
    localparam int WatchdogNs      =
        (ResetCycles + PlannedAccesses * (AccessLimit + 2)) * ClockPeriod;

    logic                clk;
    logic                reset;
    logic [AddrBits-1:0] addr;
    logic [WordBits-1:0] dataIn;
    logic                rd;
    logic                wr;
    logic [WordBits-1:0] dataOut;
    logic                done;
    logic                stall;
    logic                cacheHit;

    // Word-addressed shadow of main memory
    logic [WordBits-1:0] shadowMem   [2 ** (AddrBits - 1)];
    bit                  shadowKnown [2 ** (AddrBits - 1)];
    logic [TagBits-1:0]  shadowTag   [2 ** IndexBits];
    bit                  shadowValid [2 ** IndexBits];

    int     mismatches;
    int     failures;
    integer seed;

    clockGen #(
        .Period(ClockPeriod),
        .ResetCycles(ResetCycles)
    ) i_clk (
        .clk(clk),
        .reset(reset)
    );

    memSystem #(
        .BankLatency(BankLatency)
    ) i_dut (
        .clk(clk),
        .reset(reset),
        .addr(addr),
        .dataIn(dataIn),
        .rd(rd),
        .wr(wr),
        .dataOut(dataOut),
        .done(done),
        .stall(stall),
        .cacheHit(cacheHit)
    );

    // Tag, index, word offset, then the unused byte bit
    function automatic logic [AddrBits-1:0] makeAddr(input int tag, input int index,
                                                     input int offset);
        return {TagBits'(tag), IndexBits'(index), OffsetBits'(offset), 1'b0};
    endfunction

    function automatic logic [TagBits-1:0] lineTag(input logic [AddrBits-1:0] a);
        return a[AddrBits-1 -: TagBits];
    endfunction

    function automatic logic [IndexBits-1:0] lineIndex(input logic [AddrBits-1:0] a);
        return a[AddrBits-TagBits-1 -: IndexBits];
    endfunction

    function automatic logic [WordBits-1:0] randomWord();
        return WordBits'($random(seed));
    endfunction

    task automatic reportMismatch(input string msg);
        mismatches++;
        $display("MISMATCH at %0d ns: %s", $time, msg);
    endtask

    task automatic reportFailure(input string msg);
        failures++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    // One request held until done, stall checked every cycle on the way
    task automatic runAccess(input logic isWrite, input logic [AddrBits-1:0] a,
                             input logic [WordBits-1:0] d, output int cycles,
                             output logic gotHit, output logic [WordBits-1:0] gotData);
        bit finished;
        finished = 1'b0;
        cycles   = 0;
        gotHit   = 1'b0;
        gotData  = '0;
        @(posedge clk);
        addr   <= a;
        dataIn <= d;
        rd     <= !isWrite;
        wr     <= isWrite;
        while (!finished && cycles < AccessLimit) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (done === 1'b1) begin
                finished = 1'b1;
                gotHit   = cacheHit;
                gotData  = dataOut;
                if (stall !== 1'b0) begin
                    reportMismatch($sformatf("stall %b in done cycle, expected 0", stall));
                end
            end else if (stall !== 1'b1) begin
                reportMismatch($sformatf("stall %b while %h pending, expected 1", stall, a));
            end
        end
        if (!finished) begin
            reportFailure($sformatf("no done within %0d cycles for access to %h",
                                    AccessLimit, a));
        end
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
        @(negedge clk);
        if (done !== 1'b0) begin
            reportMismatch("done high for more than one cycle");
        end
    endtask

    task automatic writeWord(input logic [AddrBits-1:0] a, input logic [WordBits-1:0] d);
        int                  cycles;
        logic                gotHit;
        logic [WordBits-1:0] gotData;
        runAccess(1'b1, a, d, cycles, gotHit, gotData);
        if (gotHit !== 1'b0) begin
            reportMismatch($sformatf("write %h: cacheHit %b, expected 0", a, gotHit));
        end
        shadowMem[a[AddrBits-1:1]]   = d;   // Write-through, no allocate
        shadowKnown[a[AddrBits-1:1]] = 1'b1;
    endtask

    task automatic readWord(input logic [AddrBits-1:0] a);
        int                   cycles;
        logic                 gotHit;
        logic [WordBits-1:0]  gotData;
        logic                 expHit;
        logic [IndexBits-1:0] idx;
        idx    = lineIndex(a);
        expHit = shadowValid[idx] && (shadowTag[idx] == lineTag(a));
        runAccess(1'b0, a, '0, cycles, gotHit, gotData);
        if (gotHit !== expHit) begin
            reportMismatch($sformatf("read %h: cacheHit %b, expected %b", a, gotHit, expHit));
        end
        if (expHit && cycles != HitLatency) begin
            reportMismatch($sformatf("read hit %h took %0d cycles, expected %0d",
                                     a, cycles, HitLatency));
        end
        if (shadowKnown[a[AddrBits-1:1]] && gotData !== shadowMem[a[AddrBits-1:1]]) begin
            reportMismatch($sformatf("read %h: data %h, expected %h",
                                     a, gotData, shadowMem[a[AddrBits-1:1]]));
        end
        shadowValid[idx] = 1'b1;   // Line now filled
        shadowTag[idx]   = lineTag(a);
    endtask

    task automatic testReset();
        $display("Test 1: reset state and first read");
        if (done !== 1'b0 || stall !== 1'b0 || cacheHit !== 1'b0) begin
            reportMismatch($sformatf("after reset done %b stall %b cacheHit %b, expected 0",
                                     done, stall, cacheHit));
        end
        readWord(makeAddr(1, 8'h10, 0));
    endtask

    task automatic testWriteThenRead();
        logic [AddrBits-1:0] lineAddr [4];
        $display("Test 2: write-through then read back");
        for (int i = 0; i < 4; i++) begin
            lineAddr[i] = makeAddr(2, 8'h20 + i, i);
            writeWord(lineAddr[i], randomWord());
        end
        for (int i = 0; i < 4; i++) begin
            readWord(lineAddr[i]);   // Miss, fills the line
            readWord(lineAddr[i]);   // Two-cycle hit
        end
    endtask

    task automatic testFillLine();
        $display("Test 3: one fill covers the whole line");
        for (int i = 0; i < 4; i++) begin
            writeWord(makeAddr(3, 8'h40, i), randomWord());
        end
        readWord(makeAddr(3, 8'h40, 2));
        readWord(makeAddr(3, 8'h40, 0));
        readWord(makeAddr(3, 8'h40, 1));
        readWord(makeAddr(3, 8'h40, 3));
    endtask

    task automatic testWriteHit();
        $display("Test 4: write hit updates the cached word");
        writeWord(makeAddr(3, 8'h40, 1), randomWord());
        readWord(makeAddr(3, 8'h40, 1));
    endtask

    task automatic testConflict();
        logic [AddrBits-1:0] first;
        logic [AddrBits-1:0] second;
        $display("Test 5: conflict eviction on one index");
        first  = makeAddr(4, 8'h50, 0);
        second = makeAddr(9, 8'h50, 0);
        writeWord(first, randomWord());
        writeWord(second, randomWord());
        repeat (3) begin
            readWord(first);
            readWord(second);
        end
    endtask

    // Mixed traffic on a small pool, stall checked inside every access
    task automatic testStall();
        logic [AddrBits-1:0] a;
        $display("Test 6: stall over mixed reads and writes");
        for (int i = 0; i < 24; i++) begin
            a = makeAddr($random(seed) & 3, 8'h60 + ($random(seed) & 3), $random(seed) & 3);
            if (($random(seed) & 1) != 0) begin
                writeWord(a, randomWord());
            end else begin
                readWord(a);
            end
        end
    endtask

    initial begin
        rd         = 1'b0;
        wr         = 1'b0;
        addr       = '0;
        dataIn     = '0;
        seed       = 32'h87ca;
        mismatches = 0;
        failures   = 0;
        @(negedge clk);
        while (reset) @(negedge clk);
        testReset();
        testWriteThenRead();
        testFillLine();
        testWriteHit();
        testConflict();
        testStall();
        repeat (2) @(posedge clk);
        $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Limit sized for every planned access taking the worst miss time
    initial begin
        #(WatchdogNs);
        $display("Watchdog expired after %0d ns, the tests did not finish", WatchdogNs);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/bankedMem.sv ====
/*
 * Four-bank main memory
 * Each bank takes one command, then stays busy for BankLatency cycles.
 * A read word is captured at issue and returned in the last busy cycle.
 * Banks count independently, so several accesses overlap.
 */
`timescale 1ns/10ps
`default_nettype none

module bankedMem
    import memSysPkg::*;
    import cacheCtrlPkg::*;
#(
    parameter int BankLatency = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  bankCmd              cmd,
    input  logic                cmdValid,
    output logic [NumBanks-1:0] busy,
    output bankRet              ret,
    output logic                retValid
);

    localparam int RowDepth  = 2 ** RowBits;
    localparam int CountBits = $clog2(BankLatency + 1);

    logic [OffsetBits-1:0]             cmdBank;
    logic [RowBits-1:0]                cmdRow;
    logic [NumBanks-1:0]               retHere;
    logic [NumBanks-1:0][WordBits-1:0] bankWord;

    assign cmdBank = addrOffset(cmd.addr);
    assign cmdRow  = addrRow(cmd.addr);

    for (genvar b = 0; b < NumBanks; b++) begin : gBank
        logic [WordBits-1:0]  store [RowDepth];
        logic [CountBits-1:0] count;
        logic                 pendingRead;
        logic [WordBits-1:0]  heldWord;
        logic                 selected;

        assign selected = cmdValid && (cmdBank == OffsetBits'(b));

        always_ff @(posedge clk) begin
            if (reset) begin
                count       <= '0;
                pendingRead <= 1'b0;
            end else if (selected) begin
                count       <= CountBits'(BankLatency);
                pendingRead <= !cmd.write;
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (selected && cmd.write) begin
                store[cmdRow] <= cmd.data;
            end
            if (selected && !cmd.write) begin
                heldWord <= store[cmdRow];   // Latched at issue
            end
        end

        assign busy[b]     = (count != '0);
        assign retHere[b]  = pendingRead && (count == CountBits'(1));
        assign bankWord[b] = heldWord;
    end

    // Commands issue one per cycle, so at most one bank expires at a time
    always_comb begin
        ret      = '0;
        retValid = 1'b0;
        for (int b = 0; b < NumBanks; b++) begin
            if (retHere[b]) begin
                ret.data = bankWord[b];
                ret.bank = OffsetBits'(b);
                retValid = 1'b1;
            end
        end
    end

    aNoBusyCmd: assert property (
        @(posedge clk) disable iff (reset)
        cmdValid |-> !busy[cmdBank]
    ) else $error("command to busy bank %0d", cmdBank);

endmodule

`default_nettype wire

// ==== src/cacheArray.sv ====
/*
 * Direct-mapped cache store
 * 256 lines of tag, valid bit and four words. Lookup and read are
 * combinational; hit is tag equality on a valid line. A write stores
 * one word and loads the tag and valid bit of the addressed line.
 */
`timescale 1ns/10ps
`default_nettype none

module cacheArray
    import memSysPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [TagBits-1:0]    tag,
    input  logic [IndexBits-1:0]  index,
    input  logic [OffsetBits-1:0] offset,
    input  logic [WordBits-1:0]   wdata,
    input  logic                  write,
    input  logic                  validIn,
    output logic                  hit,
    output logic [WordBits-1:0]   rdata
);

    localparam int NumLines     = 2 ** IndexBits;
    localparam int WordsPerLine = 2 ** OffsetBits;

    logic [NumLines-1:0] lineValid;   // Flop vector, cleared in one cycle
    logic [TagBits-1:0]  tagStore [NumLines];
    logic [WordsPerLine-1:0][WordBits-1:0] dataStore [NumLines];

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            lineValid <= '0;
        end else if (write) begin
            lineValid[index] <= validIn;
        end
    end

    // Tag and data words
    always_ff @(posedge clk) begin
        if (write) begin
            tagStore[index]          <= tag;
            dataStore[index][offset] <= wdata;
        end
    end

    assign hit   = lineValid[index] && (tagStore[index] == tag);
    assign rdata = dataStore[index][offset];

    // An unknown offset would corrupt a word of the line silently
    aWriteOffsetKnown: assert property (
        @(posedge clk) disable iff (reset)
        write |-> !$isunknown(offset)
    ) else $error("cache write with unknown offset");

endmodule

`default_nettype wire

// ==== src/cacheController.sv ====
/*
 * Cache controller
 * Serves read hits in two cycles, fills a missed line across the four
 * banks with overlapping reads, and sends every write through to memory
 * while updating the cached word on a hit.
 */
`timescale 1ns/10ps
`default_nettype none

module cacheController
    import memSysPkg::*;
    import cacheCtrlPkg::*;
#(
    parameter int BankLatency = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  memReq                 req,
    input  logic                  rd,
    input  logic                  hit,
    input  logic [WordBits-1:0]   arrayData,
    input  logic [NumBanks-1:0]   busy,
    input  bankRet                ret,
    input  logic                  retValid,
    output logic                  arrayWrite,
    output logic [OffsetBits-1:0] arrayOffset,
    output logic [WordBits-1:0]   arrayWdata,
    output logic                  arrayValid,
    output bankCmd                cmd,
    output logic                  cmdValid,
    output logic [WordBits-1:0]   dataOut,
    output logic                  done,
    output logic                  stall,
    output logic                  cacheHit
);

    ctrlState              state;
    ctrlState              stateNext;
    logic [NumBanks-1:0]   issued;        // Fill reads sent
    logic [NumBanks-1:0]   returned;      // Fill words written
    logic [NumBanks-1:0]   issuedNext;
    logic [NumBanks-1:0]   returnedNext;
    logic [OffsetBits-1:0] reqOffset;
    logic [OffsetBits-1:0] fillBank;
    logic                  doneNext;
    logic                  hitNext;

    assign reqOffset = addrOffset(req.addr);

    // Banks are fetched in order, lowest one not yet sent
    always_comb begin
        fillBank = '0;
        for (int i = NumBanks - 1; i >= 0; i--) begin
            if (!issued[i]) begin
                fillBank = OffsetBits'(i);
            end
        end
    end

    always_comb begin
        stateNext    = state;
        issuedNext   = issued;
        returnedNext = returned;
        arrayWrite   = 1'b0;
        arrayOffset  = reqOffset;
        arrayWdata   = req.data;
        arrayValid   = 1'b1;
        cmd          = '{addr: req.addr, data: req.data, write: 1'b1};
        cmdValid     = 1'b0;
        doneNext     = 1'b0;
        hitNext      = 1'b0;
        case (state)
            Idle: begin
                // Request still held in the done cycle
                if ((rd || req.write) && !done) begin
                    stateNext = CompareTag;
                end
            end
            CompareTag: begin
                if (req.write) begin
                    arrayWrite = hit;   // No allocate on a write miss
                    stateNext  = WriteMem;
                end else if (hit) begin
                    doneNext  = 1'b1;
                    hitNext   = (returned == '0);   // Low after a fill
                    stateNext = Idle;
                end else begin
                    stateNext = Fill;
                end
            end
            Fill: begin
                cmd.addr  = {addrRow(req.addr), fillBank, 1'b0};
                cmd.write = 1'b0;
                cmdValid  = !(&issued) && !busy[fillBank];
                if (cmdValid) begin
                    issuedNext[fillBank] = 1'b1;
                end
                if (retValid) begin
                    arrayWrite             = 1'b1;
                    arrayOffset            = ret.bank;
                    arrayWdata             = ret.data;
                    arrayValid             = 1'b0;   // Line invalid until complete
                    returnedNext[ret.bank] = 1'b1;
                end
                if (&returnedNext) begin
                    stateNext = FillWrite;
                end
            end
            FillWrite: begin
                arrayWrite = 1'b1;
                arrayWdata = arrayData;   // Rewrite own word, set valid
                stateNext  = CompareTag;
            end
            WriteMem: begin
                cmdValid = !busy[reqOffset];
                if (cmdValid) begin
                    doneNext  = 1'b1;
                    stateNext = Idle;
                end
            end
            default: stateNext = Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= Idle;
            issued   <= '0;
            returned <= '0;
            done     <= 1'b0;
            cacheHit <= 1'b0;
        end else begin
            state    <= stateNext;
            issued   <= (state == Idle) ? '0 : issuedNext;
            returned <= (state == Idle) ? '0 : returnedNext;
            done     <= doneNext;
            cacheHit <= hitNext;
        end
    end

    always_ff @(posedge clk) begin
        if (doneNext && !req.write) begin
            dataOut <= arrayData;
        end
    end

    assign stall = (state != Idle);

    aCmdBankFree: assert property (
        @(posedge clk) disable iff (reset)
        cmdValid |-> !busy[addrOffset(cmd.addr)]
    ) else $error("controller issued to a busy bank");

    aDonePulse: assert property (
        @(posedge clk) disable iff (reset)
        done |=> !done
    ) else $error("done wider than one cycle");

    // Each fill read comes back when its bank stops counting
    aFillReturn: assert property (
        @(posedge clk) disable iff (reset)
        (cmdValid && !cmd.write) |-> ##BankLatency retValid
    ) else $error("fill return missing after %0d cycles", BankLatency);

endmodule

`default_nettype wire

// ==== src/cacheCtrlPkg.sv ====
/*
 * Cache controller definitions
 * Controller states and the command and return records exchanged
 * between the controller and the banked memory.
 */
`default_nettype none

package cacheCtrlPkg;

    import memSysPkg::*;

    typedef enum logic [2:0] {
        Idle,
        CompareTag,
        Fill,        // Line fetch, up to four reads in flight
        FillWrite,   // Marks the filled line valid
        WriteMem
    } ctrlState;

    // Single cycle access, bank taken from the word offset of addr
    typedef struct packed {
        logic [AddrBits-1:0] addr;
        logic [WordBits-1:0] data;
        logic                write;
    } bankCmd;

    typedef struct packed {
        logic [WordBits-1:0]   data;
        logic [OffsetBits-1:0] bank;
    } bankRet;

endpackage

`default_nettype wire

// ==== src/memSysPkg.sv ====
/*
 * Memory system definitions
 * Address field layout, word width, bank count and the processor
 * request that travels from the top level into the cache controller.
 */
`default_nettype none

package memSysPkg;

    localparam int WordBits   = 16;
    localparam int TagBits    = 5;
    localparam int IndexBits  = 8;
    localparam int OffsetBits = 2;
    localparam int NumBanks   = 4;   // Word n of a line lives in bank n

    // Lowest bit selects a byte and is ignored
    localparam int AddrBits = TagBits + IndexBits + OffsetBits + 1;
    localparam int RowBits  = TagBits + IndexBits;   // Row inside one bank

    typedef struct packed {
        logic [AddrBits-1:0] addr;
        logic [WordBits-1:0] data;
        logic                write;
    } memReq;

    function automatic logic [TagBits-1:0] addrTag(input logic [AddrBits-1:0] a);
        return a[AddrBits-1 -: TagBits];
    endfunction

    function automatic logic [IndexBits-1:0] addrIndex(input logic [AddrBits-1:0] a);
        return a[OffsetBits+1 +: IndexBits];
    endfunction

    function automatic logic [OffsetBits-1:0] addrOffset(input logic [AddrBits-1:0] a);
        return a[1 +: OffsetBits];
    endfunction

    function automatic logic [RowBits-1:0] addrRow(input logic [AddrBits-1:0] a);
        return a[AddrBits-1 -: RowBits];
    endfunction

endpackage

`default_nettype wire

// ==== src/memSystem.sv ====
/*
 * Memory system top level
 * Direct-mapped write-through cache in front of a four-bank memory.
 */
`timescale 1ns/10ps
`default_nettype none

module memSystem
    import memSysPkg::*;
    import cacheCtrlPkg::*;
#(
    parameter int BankLatency = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [AddrBits-1:0] addr,
    input  logic [WordBits-1:0] dataIn,
    input  logic                rd,
    input  logic                wr,
    output logic [WordBits-1:0] dataOut,
    output logic                done,
    output logic                stall,
    output logic                cacheHit
);

    memReq                 req;
    logic                  hit;
    logic [WordBits-1:0]   arrayData;
    logic                  arrayWrite;
    logic [OffsetBits-1:0] arrayOffset;
    logic [WordBits-1:0]   arrayWdata;
    logic                  arrayValid;
    bankCmd                cmd;
    logic                  cmdValid;
    logic [NumBanks-1:0]   busy;
    bankRet                ret;
    logic                  retValid;

    assign req = '{addr: addr, data: dataIn, write: wr};

    cacheController #(
        .BankLatency(BankLatency)
    ) i_ctrl (
        .clk(clk),
        .reset(reset),
        .req(req),
        .rd(rd),
        .hit(hit),
        .arrayData(arrayData),
        .busy(busy),
        .ret(ret),
        .retValid(retValid),
        .arrayWrite(arrayWrite),
        .arrayOffset(arrayOffset),
        .arrayWdata(arrayWdata),
        .arrayValid(arrayValid),
        .cmd(cmd),
        .cmdValid(cmdValid),
        .dataOut(dataOut),
        .done(done),
        .stall(stall),
        .cacheHit(cacheHit)
    );

    // Lookup fields come straight from the held request address
    cacheArray i_array (
        .clk(clk),
        .reset(reset),
        .tag(addrTag(addr)),
        .index(addrIndex(addr)),
        .offset(arrayOffset),
        .wdata(arrayWdata),
        .write(arrayWrite),
        .validIn(arrayValid),
        .hit(hit),
        .rdata(arrayData)
    );

    bankedMem #(
        .BankLatency(BankLatency)
    ) i_mem (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .cmdValid(cmdValid),
        .busy(busy),
        .ret(ret),
        .retValid(retValid)
    );

endmodule

`default_nettype wire
